// ==== rv_pkg.sv ====
package rv_pkg;

    typedef logic [63:0] xlen_t;                        // Architectural register width

    // Major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // Minor function codes
    localparam logic [2:0] F3_ADDI  = 3'b000;
    localparam logic [2:0] F3_SLT   = 3'b010;
    localparam logic [2:0] F3_BEQ   = 3'b000;
    localparam logic [2:0] F3_JALR  = 3'b000;
    localparam logic [2:0] F3_DW    = 3'b011;           // Doubleword load and store
    localparam logic [2:0] F3_CSRRW = 3'b001;
    localparam logic [6:0] F7_BASE  = 7'b0000000;
    localparam logic [31:0] INSN_MRET = 32'h3020_0073;  // Fully fixed encoding

    // Machine CSRs reachable by CSRRW
    localparam logic [11:0] CSR_MSTATUS = 12'h300;
    localparam logic [11:0] CSR_MTVEC   = 12'h305;
    localparam logic [11:0] CSR_MEPC    = 12'h341;
    localparam logic [11:0] CSR_MCAUSE  = 12'h342;

    localparam int MSTATUS_MIE  = 3;                    // Global interrupt enable
    localparam int MSTATUS_MPIE = 7;                    // Enable saved on trap entry
    // Interrupt flag in MSB, cause 11 is machine external
    localparam xlen_t MCAUSE_EXT_IRQ = 64'h8000_0000_0000_000B;

    typedef enum logic [3:0] {
        OP_LUI, OP_AUIPC, OP_ADDI, OP_SLT, OP_BEQ, OP_JAL, OP_JALR,
        OP_LD, OP_SD, OP_MRET, OP_CSRRW,
        OP_NOP                                          // Unknown opcodes land here
    } op_kind_e;

    typedef struct packed {
        op_kind_e    kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        xlen_t       imm;                               // Sign-extended, format already picked
        logic [11:0] csr_addr;
        xlen_t       pc;                                // Address of this instruction
    } dec_op_t;

endpackage

// ==== rv_if.sv ====
`timescale 1ns/10ps

// Decode to execute, one decoded op per transfer
interface dec_if import rv_pkg::*; ();
    logic    valid;                 // Op held until ready
    logic    ready;                 // Execute idle
    dec_op_t op;

    modport source (output valid, output op, input ready);
    modport sink   (input valid, input op, output ready);
endinterface

// Execute to retire, result plus the operand read-back paths
interface res_if import rv_pkg::*; ();
    logic        valid;
    logic        ready;             // Retire never stalls
    logic        wr_en;             // Already masked for x0
    logic [4:0]  rd;
    xlen_t       data;
    xlen_t       next_pc;
    logic        is_mret;
    logic        csr_wr_en;
    logic [11:0] csr_addr;          // Also selects csr_rdata
    xlen_t       csr_data;
    logic [4:0]  rs1_sel;
    logic [4:0]  rs2_sel;
    xlen_t       rs1_val;           // Combinational register file reads
    xlen_t       rs2_val;
    xlen_t       csr_rdata;

    modport source (
        output valid, wr_en, rd, data, next_pc, is_mret,
        output csr_wr_en, csr_addr, csr_data, rs1_sel, rs2_sel,
        input  ready, rs1_val, rs2_val, csr_rdata
    );
    modport sink (
        input  valid, wr_en, rd, data, next_pc, is_mret,
        input  csr_wr_en, csr_addr, csr_data, rs1_sel, rs2_sel,
        output ready, rs1_val, rs2_val, csr_rdata
    );
endinterface

// ==== rv_decode.sv ====
`timescale 1ns/10ps

module rv_decode import rv_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  xlen_t       pc,
    input  logic        instr_valid,
    input  logic [31:0] instruction,
    output logic        instr_ready,
    input  logic        retired,        // Retire pulse reopens fetch
    dec_if.source       dec
);

    logic [31:0] ir;                    // Captured instruction word
    xlen_t       ir_pc;
    logic        ir_full;               // ir waits one cycle for decode

    function automatic dec_op_t decode_ir(input logic [31:0] w, input xlen_t at_pc);
        dec_op_t d;
        xlen_t   imm_i;
        xlen_t   imm_s;
        xlen_t   imm_b;
        xlen_t   imm_u;
        xlen_t   imm_j;
        imm_i = {{52{w[31]}}, w[31:20]};
        imm_s = {{52{w[31]}}, w[31:25], w[11:7]};
        imm_b = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        imm_u = {{32{w[31]}}, w[31:12], 12'b0};
        imm_j = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        d.kind     = OP_NOP;            // Retires without a write
        d.rd       = w[11:7];
        d.rs1      = w[19:15];
        d.rs2      = w[24:20];
        d.imm      = imm_i;             // I-type is the common case
        d.csr_addr = w[31:20];
        d.pc       = at_pc;
        case (w[6:0])
            OPC_LUI:    begin d.kind = OP_LUI;   d.imm = imm_u; end
            OPC_AUIPC:  begin d.kind = OP_AUIPC; d.imm = imm_u; end
            OPC_JAL:    begin d.kind = OP_JAL;   d.imm = imm_j; end
            OPC_OPIMM:  if (w[14:12] == F3_ADDI) d.kind = OP_ADDI;
            OPC_OP:     if (w[14:12] == F3_SLT && w[31:25] == F7_BASE) d.kind = OP_SLT;
            OPC_JALR:   if (w[14:12] == F3_JALR) d.kind = OP_JALR;
            OPC_LOAD:   if (w[14:12] == F3_DW) d.kind = OP_LD;
            OPC_BRANCH: if (w[14:12] == F3_BEQ) begin
                d.kind = OP_BEQ;
                d.imm  = imm_b;
            end
            OPC_STORE:  if (w[14:12] == F3_DW) begin
                d.kind = OP_SD;
                d.imm  = imm_s;
            end
            OPC_SYSTEM: begin
                if (w == INSN_MRET) d.kind = OP_MRET;
                else if (w[14:12] == F3_CSRRW) d.kind = OP_CSRRW;
            end
            default: ;
        endcase
        return d;
    endfunction

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            instr_ready <= 1'b1;
            ir_full     <= 1'b0;
            dec.valid   <= 1'b0;
        end else begin
            if (instr_valid && instr_ready) begin
                instr_ready <= 1'b0;    // Closed until retirement
                ir_full     <= 1'b1;
            end else if (retired) begin
                instr_ready <= 1'b1;
            end
            if (ir_full) begin
                ir_full   <= 1'b0;
                dec.valid <= 1'b1;      // Op visible from N+1
            end else if (dec.valid && dec.ready) begin
                dec.valid <= 1'b0;
            end
        end
    end

    // Fetch and decode payload
    always_ff @(posedge clk) begin
        if (instr_valid && instr_ready) begin
            ir    <= instruction;
            ir_pc <= pc;
        end
        if (ir_full) dec.op <= decode_ir(ir, ir_pc);   // Loaded once, stable while valid
    end

endmodule

// ==== rv_execute.sv ====
`timescale 1ns/10ps

module rv_execute import rv_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    dec_if.sink   dec,
    res_if.source res,
    output xlen_t bus_address,
    output xlen_t bus_write_data,
    output logic  bus_write_enable,
    output logic  bus_read_enable,
    input  xlen_t bus_read_data,
    input  logic  bus_read_valid        // No ready on this bus
);

    typedef enum logic [1:0] {S_IDLE, S_WAIT_RD, S_HAND} state_e;

    state_e  state;
    dec_op_t op_q;                      // Op being executed
    xlen_t   load_q;                    // Returned load data
    xlen_t   rs1_imm;                   // Shared adder for ADDI, JALR, LD and SD
    xlen_t   pc_imm;                    // AUIPC, BEQ and JAL target
    xlen_t   link;

    assign dec.ready   = (state == S_IDLE);
    assign res.valid   = (state == S_HAND);
    assign res.rs1_sel = op_q.rs1;      // Register file cannot change while in flight
    assign res.rs2_sel = op_q.rs2;

    assign rs1_imm        = res.rs1_val + op_q.imm;
    assign pc_imm         = op_q.pc + op_q.imm;
    assign link           = op_q.pc + 64'd4;
    assign bus_address    = rs1_imm;
    assign bus_write_data = res.rs2_val;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state            <= S_IDLE;
            bus_read_enable  <= 1'b0;
            bus_write_enable <= 1'b0;
        end else begin
            bus_read_enable  <= 1'b0;   // Enables are one-cycle pulses
            bus_write_enable <= 1'b0;
            case (state)
                S_IDLE: if (dec.valid) begin
                    if (dec.op.kind == OP_LD) begin
                        state           <= S_WAIT_RD;
                        bus_read_enable <= 1'b1;
                    end else begin
                        state            <= S_HAND;     // Store retires one cycle after write
                        bus_write_enable <= (dec.op.kind == OP_SD);
                    end
                end
                S_WAIT_RD: if (bus_read_valid) state <= S_HAND;   // Variable latency
                S_HAND:    if (res.ready) state <= S_IDLE;
                default:   state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (dec.valid && dec.ready) op_q <= dec.op;
        if (state == S_WAIT_RD && bus_read_valid) load_q <= bus_read_data;
    end

    always_comb begin
        res.rd        = op_q.rd;
        res.wr_en     = 1'b0;
        res.data      = link;           // Link value for both jumps
        res.next_pc   = link;
        res.is_mret   = 1'b0;
        res.csr_wr_en = 1'b0;
        res.csr_addr  = op_q.csr_addr;
        res.csr_data  = res.rs1_val;
        case (op_q.kind)
            OP_LUI:   begin res.wr_en = 1'b1; res.data = op_q.imm; end
            OP_AUIPC: begin res.wr_en = 1'b1; res.data = pc_imm; end
            OP_ADDI:  begin res.wr_en = 1'b1; res.data = rs1_imm; end
            OP_SLT: begin
                res.wr_en = 1'b1;
                res.data  = ($signed(res.rs1_val) < $signed(res.rs2_val)) ? 64'd1 : 64'd0;
            end
            OP_BEQ:   if (res.rs1_val == res.rs2_val) res.next_pc = pc_imm;
            OP_JAL:   begin res.wr_en = 1'b1; res.next_pc = pc_imm; end
            OP_JALR:  begin res.wr_en = 1'b1; res.next_pc = {rs1_imm[63:1], 1'b0}; end
            OP_LD:    begin res.wr_en = 1'b1; res.data = load_q; end
            OP_MRET:  res.is_mret = 1'b1;   // Retire picks mepc
            OP_CSRRW: begin
                res.wr_en     = 1'b1;
                res.data      = res.csr_rdata;  // Old value, write lands at retire
                res.csr_wr_en = 1'b1;
            end
            default: ;                      // SD and NOP write nothing
        endcase
        if (op_q.rd == 5'd0) res.wr_en = 1'b0;  // x0 stays zero
    end

endmodule

// ==== rv_retire.sv ====
`timescale 1ns/10ps

module rv_retire import rv_pkg::*; #(
    parameter xlen_t RAM_BASE  = 64'h8000_0000,
    parameter xlen_t TRAP_BASE = 64'h8000_0200
) (
    input  logic       clk,
    input  logic       reset,
    res_if.sink        res,
    input  logic       interrupt_request,
    output logic       interrupt_ack,
    output xlen_t      pc,              // Next fetch address
    output logic       retired,
    output logic       retire_valid,
    output xlen_t      retire_pc,
    output logic [4:0] retire_rd,
    output xlen_t      retire_data
);

    xlen_t regs [0:31];                 // Entry 0 never written
    xlen_t mstatus;
    xlen_t mepc;
    xlen_t mcause;
    xlen_t mtvec;
    logic  take_irq;

    assign res.ready   = 1'b1;
    assign retired     = retire_valid;
    assign res.rs1_val = (res.rs1_sel == 5'd0) ? '0 : regs[res.rs1_sel];
    assign res.rs2_val = (res.rs2_sel == 5'd0) ? '0 : regs[res.rs2_sel];
    // Retirement wins over a pending interrupt
    assign take_irq = interrupt_request && mstatus[MSTATUS_MIE] && !res.valid;

    always_comb begin
        case (res.csr_addr)
            CSR_MSTATUS: res.csr_rdata = mstatus;
            CSR_MEPC:    res.csr_rdata = mepc;
            CSR_MCAUSE:  res.csr_rdata = mcause;
            CSR_MTVEC:   res.csr_rdata = mtvec;
            default:     res.csr_rdata = '0;    // Unimplemented CSRs read zero
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc            <= RAM_BASE;
            mstatus       <= 64'(1) << MSTATUS_MIE;     // Interrupts enabled out of reset
            mepc          <= '0;
            mcause        <= '0;
            mtvec         <= TRAP_BASE;
            retire_valid  <= 1'b0;
            interrupt_ack <= 1'b0;
        end else begin
            retire_valid  <= 1'b0;
            interrupt_ack <= 1'b0;
            if (res.valid && res.ready) begin
                retire_valid <= 1'b1;
                if (res.is_mret) begin
                    pc                    <= mepc;
                    mstatus[MSTATUS_MIE]  <= mstatus[MSTATUS_MPIE];
                    mstatus[MSTATUS_MPIE] <= 1'b1;
                end else begin
                    pc <= res.next_pc;
                end
                if (res.csr_wr_en) begin
                    case (res.csr_addr)
                        CSR_MSTATUS: mstatus <= res.csr_data;
                        CSR_MEPC:    mepc    <= res.csr_data;
                        CSR_MCAUSE:  mcause  <= res.csr_data;
                        CSR_MTVEC:   mtvec   <= res.csr_data;
                        default: ;
                    endcase
                end
            end else if (take_irq) begin
                mepc                  <= pc;            // Resume where fetch would have gone
                mcause                <= MCAUSE_EXT_IRQ;
                mstatus[MSTATUS_MPIE] <= mstatus[MSTATUS_MIE];
                mstatus[MSTATUS_MIE]  <= 1'b0;
                pc                    <= mtvec;
                interrupt_ack         <= 1'b1;
            end
        end
    end

    // Write-back and observation payload
    always_ff @(posedge clk) begin
        if (res.valid && res.ready) begin
            if (res.wr_en) regs[res.rd] <= res.data;
            retire_pc   <= pc;          // pc still points at the retiring instruction
            retire_rd   <= res.rd;
            retire_data <= res.data;
        end
    end

endmodule

// ==== rv_core.sv ====
`timescale 1ns/10ps

module rv_core import rv_pkg::*; #(
    parameter xlen_t RAM_BASE  = 64'h8000_0000,
    parameter xlen_t TRAP_BASE = 64'h8000_0200
) (
    input  logic        clk,
    input  logic        reset,
    output xlen_t       pc,
    input  logic        instr_valid,
    input  logic [31:0] instruction,
    output logic        instr_ready,
    output xlen_t       bus_address,
    output xlen_t       bus_write_data,
    output logic        bus_write_enable,
    output logic        bus_read_enable,
    input  xlen_t       bus_read_data,
    input  logic        bus_read_valid,
    input  logic        interrupt_request,
    output logic        interrupt_ack,
    output logic        retire_valid,
    output xlen_t       retire_pc,
    output logic [4:0]  retire_rd,
    output xlen_t       retire_data
);

    dec_if dec_bus ();
    res_if res_bus ();

    logic retired;
    logic irq_idle;                     // Request seen only with nothing in flight

    // Idle fetch side, and no fetch landing on the entry edge
    assign irq_idle = interrupt_request && instr_ready && !instr_valid;

    rv_decode rv_decode_inst (
        .clk, .reset, .pc, .instr_valid, .instruction, .instr_ready,
        .retired, .dec(dec_bus.source)
    );

    rv_execute rv_execute_inst (
        .clk, .reset, .dec(dec_bus.sink), .res(res_bus.source),
        .bus_address, .bus_write_data, .bus_write_enable, .bus_read_enable,
        .bus_read_data, .bus_read_valid
    );

    rv_retire #(.RAM_BASE(RAM_BASE), .TRAP_BASE(TRAP_BASE)) rv_retire_inst (
        .clk, .reset, .res(res_bus.sink),
        .interrupt_request(irq_idle), .interrupt_ack,
        .pc, .retired, .retire_valid, .retire_pc, .retire_rd, .retire_data
    );

endmodule

// ==== rv_core_sva.sv ====
`timescale 1ns/10ps

module rv_core_sva (
    input logic clk,
    input logic reset,
    input logic instr_valid,
    input logic instr_ready,
    input logic retire_valid,
    input logic interrupt_ack,
    input logic bus_read_enable,
    input logic bus_write_enable
);

    logic in_flight;                    // From the fetch handshake to retirement

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) in_flight <= 1'b0;
        else if (instr_valid && instr_ready) in_flight <= 1'b1;
        else if (retire_valid) in_flight <= 1'b0;
    end

    ack_pulse: assert property (@(posedge clk) disable iff (!reset)
        interrupt_ack |=> !interrupt_ack) else $error("interrupt_ack longer than one cycle");
    retire_pulse: assert property (@(posedge clk) disable iff (!reset)
        retire_valid |=> !retire_valid) else $error("retire_valid longer than one cycle");
    // Fetch closed from the handshake through the retire cycle
    fetch_closed: assert property (@(posedge clk) disable iff (!reset)
        in_flight |-> !instr_ready) else $error("fetch open while in flight");
    bus_onehot: assert property (@(posedge clk) disable iff (!reset)
        !(bus_read_enable && bus_write_enable)) else $error("both bus enables high");

endmodule

bind rv_core rv_core_sva rv_core_sva_inst (.*);

// ==== rv_checker.sv ====
`timescale 1ns/10ps

module rv_checker import rv_pkg::*; #(
    parameter int    NROWS      = 25,
    parameter xlen_t STORE_ADDR = 64'h0,
    parameter xlen_t STORE_DATA = 64'h0
) (
    input  logic       clk,
    input  logic       reset,
    input  xlen_t      pc,
    input  logic       retire_valid,
    input  xlen_t      retire_pc,
    input  logic [4:0] retire_rd,
    input  xlen_t      retire_data,
    input  logic       interrupt_ack,
    input  logic       bus_write_enable,
    input  xlen_t      bus_address,
    input  xlen_t      bus_write_data,
    input  xlen_t      exp_pc [NROWS],      // Address the row was fetched from
    input  logic       exp_chk [NROWS],     // Row compares rd and data
    input  logic [4:0] exp_rd [NROWS],
    input  xlen_t      exp_data [NROWS],
    input  xlen_t      exp_next [NROWS],
    input  logic       exp_wait [NROWS],    // Interrupt entry comes before this row
    output int         checked,
    output int         pass_count,
    output int         fail_count
);

    logic ack_seen;                         // Entry seen since the last retirement

    always @(posedge clk) begin
        if (!reset) begin
            checked    <= 0;
            pass_count <= 0;
            fail_count <= 0;
            ack_seen   <= 1'b0;
        end else begin
            if (interrupt_ack) begin
                if (checked < NROWS && exp_wait[checked]) ack_seen <= 1'b1;
                else begin
                    $display("Fail at %0t: interrupt_ack before row %0d, none expected",
                             $time, checked);
                    fail_count <= fail_count + 1;
                end
            end
            if (bus_write_enable) begin
                if (bus_address != STORE_ADDR || bus_write_data != STORE_DATA) begin
                    $display("Fail at %0t: store wrote %h to %h", $time, bus_write_data,
                             bus_address);
                    fail_count <= fail_count + 1;
                end
            end
            if (retire_valid) begin
                if (checked >= NROWS) begin
                    $display("A retirement came after the end of the program at %0t", $time);
                    fail_count <= fail_count + 1;
                end else if (pc == exp_next[checked] && retire_pc == exp_pc[checked]
                        && (!exp_chk[checked]
                            || (retire_rd == exp_rd[checked]
                                && retire_data == exp_data[checked]))
                        && (!exp_wait[checked] || ack_seen)) begin
                    $display("Pass row %0d", checked);
                    pass_count <= pass_count + 1;
                end else begin
                    $display("Fail at %0t: row %0d pc %h rd %0d data %h next pc %h ack %b",
                             $time, checked, retire_pc, retire_rd, retire_data, pc, ack_seen);
                    fail_count <= fail_count + 1;
                end
                checked  <= checked + 1;
                ack_seen <= 1'b0;
            end
        end
    end

endmodule

// ==== tb_rv_core.sv ====
`timescale 1ns/10ps

module tb_rv_core;
    import rv_pkg::*;

    localparam int    NROWS   = 25;
    localparam xlen_t BASE    = 64'h8000_0000;
    localparam xlen_t HANDLER = 64'h8000_0100;  // mtvec written by the program
    localparam int    LIMIT   = NROWS * 12;

    logic clk = 1'b0;
    logic reset = 1'b0;
    logic instr_valid = 1'b0;
    logic [31:0] instruction = '0;
    logic bus_read_valid = 1'b0;
    logic interrupt_request = 1'b0;
    logic instr_ready, bus_write_enable, bus_read_enable, interrupt_ack, retire_valid;
    logic [4:0] retire_rd;
    xlen_t pc, bus_address, bus_write_data, retire_pc, retire_data;
    xlen_t bus_read_data = '0;

    // Program table with one row per retirement
    xlen_t row_pc [NROWS];
    logic [31:0] row_instr [NROWS];
    logic row_raise [NROWS];                    // Raise interrupt_request before the row
    logic exp_chk [NROWS];
    logic [4:0] exp_rd [NROWS];
    xlen_t exp_data [NROWS];
    xlen_t exp_next [NROWS];
    logic exp_wait [NROWS];
    int rows = 0;
    xlen_t cur_pc = BASE;
    int checked, pass_count, fail_count;
    int cycles = 0;

    xlen_t mem [16];
    int rd_wait = 0;                            // Read latency countdown
    logic [3:0] rd_idx;

    rv_core #(.RAM_BASE(BASE)) rv_core_inst (.*);

    rv_checker #(.NROWS(NROWS), .STORE_ADDR(64'h8000_0038), .STORE_DATA(64'h11E)) checker_inst (
        .clk, .reset, .pc, .retire_valid, .retire_pc, .retire_rd, .retire_data, .interrupt_ack,
        .bus_write_enable, .bus_address, .bus_write_data, .exp_pc(row_pc), .exp_chk, .exp_rd,
        .exp_data, .exp_next, .exp_wait, .checked, .pass_count, .fail_count
    );

    always #10 clk = ~clk;

    // Instruction formats
    function automatic logic [31:0] i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                           logic [4:0] rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction
    function automatic logic [31:0] s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011};
    endfunction
    function automatic logic [31:0] b_type(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
    endfunction
    function automatic logic [31:0] j_type(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction
    function automatic logic [31:0] slt_word(logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
        return {7'b0, rs2, rs1, 3'b010, rd, 7'b0110011};
    endfunction

    task automatic add_row(logic [31:0] w, logic chk, logic [4:0] rd, xlen_t data,
                           xlen_t next, logic raise, logic wait_irq);
        if (wait_irq) cur_pc = HANDLER;         // Entry moves fetch to the handler
        row_pc[rows] = cur_pc;
        row_instr[rows] = w;
        exp_chk[rows] = chk;
        exp_rd[rows] = rd;
        exp_data[rows] = data;
        exp_next[rows] = next;
        row_raise[rows] = raise;
        exp_wait[rows] = wait_irq;
        cur_pc = next;
        rows++;
    endtask

    // Memory with 1 to 4 cycles of read latency
    always @(posedge clk) begin
        bus_read_valid <= 1'b0;
        if (!reset) begin
            for (int i = 0; i < 16; i++) mem[i] <= 64'hC0DE_0000_0000_0000 + 64'(i);
        end else begin
            if (bus_write_enable) begin
                mem[bus_address[6:3]] <= bus_write_data;
                $display("Bus write %h to %h", bus_write_data, bus_address);
            end
            if (rd_wait > 0) begin
                rd_wait <= rd_wait - 1;
                if (rd_wait == 1) begin
                    bus_read_valid <= 1'b1;
                    bus_read_data  <= mem[rd_idx];
                end
            end else if (bus_read_enable) begin
                rd_wait <= 1 + int'($urandom % 4);
                rd_idx  <= bus_address[6:3];
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == LIMIT) begin
            $display("Timeout after %0d cycles, the core stopped retiring", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h8eb6_378b));
        add_row({20'h12345, 5'd1, 7'b0110111}, 1, 1, 64'h1234_5000, BASE + 4, 0, 0);
        add_row({20'h00001, 5'd2, 7'b0010111}, 1, 2, 64'h8000_1004, BASE + 8, 0, 0);
        add_row(i_type(12'hFFB, 0, 0, 3, 7'b0010011), 1, 3, -64'sd5, BASE + 'hC, 0, 0);
        add_row(slt_word(4, 3, 1), 1, 4, 64'd1, BASE + 'h10, 0, 0);   // Negative below positive
        add_row(slt_word(5, 1, 3), 1, 5, 64'd0, BASE + 'h14, 0, 0);
        add_row(i_type(12'd7, 1, 0, 0, 7'b0010011), 1, 0, 64'h1234_5007, BASE + 'h18, 0, 0);
        add_row(i_type(12'd0, 0, 0, 6, 7'b0010011), 1, 6, 64'd0, BASE + 'h1C, 0, 0);
        add_row(b_type(13'd8, 4, 4), 0, 0, 0, BASE + 'h24, 0, 0);     // Taken
        add_row(b_type(13'd8, 5, 4), 0, 0, 0, BASE + 'h28, 0, 0);     // Not taken
        add_row(j_type(21'd12, 7), 1, 7, BASE + 'h2C, BASE + 'h34, 0, 0);
        add_row({20'h0, 5'd9, 7'b0010111}, 1, 9, BASE + 'h34, BASE + 'h38, 0, 0);
        add_row(i_type(12'h015, 9, 0, 10, 7'b1100111), 1, 10, BASE + 'h3C, BASE + 'h48, 0, 0);
        add_row(i_type(12'h123, 3, 0, 11, 7'b0010011), 1, 11, 64'h11E, BASE + 'h4C, 0, 0);
        add_row(s_type(12'd4, 11, 9), 0, 0, 0, BASE + 'h50, 0, 0);
        add_row(i_type(12'd4, 9, 3'b011, 12, 7'b0000011), 1, 12, 64'h11E, BASE + 'h54, 0, 0);
        add_row(i_type(12'd4, 9, 3'b011, 13, 7'b0000011), 1, 13, 64'h11E, BASE + 'h58, 0, 0);
        add_row({20'h0, 5'd14, 7'b0010111}, 1, 14, BASE + 'h58, BASE + 'h5C, 0, 0);
        add_row(i_type(12'h0A8, 14, 0, 14, 7'b0010011), 1, 14, HANDLER, BASE + 'h60, 0, 0);
        add_row(i_type(12'h305, 14, 1, 15, 7'b1110011), 1, 15, 64'h8000_0200, BASE + 'h64, 0, 0);
        // Handler reads mepc and mcause while a second request stays pending
        add_row(i_type(12'h341, 0, 1, 16, 7'b1110011), 1, 16, BASE + 'h64, HANDLER + 4, 1, 1);
        add_row(i_type(12'h342, 0, 1, 17, 7'b1110011), 1, 17, 64'h8000_0000_0000_000B,
                HANDLER + 8, 1, 0);
        add_row(i_type(12'h341, 16, 1, 0, 7'b1110011), 1, 0, 64'd0, HANDLER + 'hC, 0, 0);
        add_row(32'h3020_0073, 0, 0, 0, BASE + 'h64, 0, 0);             // MRET
        add_row(i_type(12'h341, 0, 1, 16, 7'b1110011), 1, 16, BASE + 'h64, HANDLER + 4, 0, 1);
        add_row(i_type(12'h300, 0, 1, 18, 7'b1110011), 1, 18, 64'h80, HANDLER + 8, 0, 0);
        repeat (2) @(posedge clk);
        reset <= 1'b1;
        for (int i = 0; i < NROWS; i++) begin
            if (row_raise[i]) interrupt_request <= 1'b1;
            if (exp_wait[i]) begin
                do @(posedge clk); while (!interrupt_ack);
                interrupt_request <= 1'b0;
            end
            do @(posedge clk); while (!(instr_ready && pc == row_pc[i]));
            instruction <= row_instr[i];
            instr_valid <= 1'b1;
            @(posedge clk);                     // Handshake edge
            instr_valid <= 1'b0;
        end
        while (checked < NROWS) @(posedge clk);
        repeat (4) @(posedge clk);              // Catch late acks
        $display("Rows %0d, passed %0d, failed %0d", checked, pass_count, fail_count);
        if (fail_count == 0 && pass_count == NROWS) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
rv_pkg.sv
rv_if.sv
rv_decode.sv
rv_execute.sv
rv_retire.sv
rv_core.sv
rv_core_sva.sv
rv_checker.sv
tb_rv_core.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_rv_core -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "^SIMULATION PASSED$" sim.log; then
    echo "run.sh: simulation ok"
else
    echo "run.sh: simulation did not pass"
    exit 1
fi
